//--- common/id_settings.svh
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// Datapath and address width
`define ID_XLEN       32
// Register file read ports used by the decode stage
`define ID_NUM_RS     2
`define ID_RF_ADDR_W  5

// Register field positions in the instruction word
`define ID_RS1_LSB    15
`define ID_RS2_LSB    20
`define ID_RD_LSB     7

`define ID_OPCODE_W   7
// Return address step for JAL and JALR
`define ID_PC_INCR    4

`endif

//--- common/id_pkg.sv
`include "id_settings.svh"

package id_pkg;

  ////////////////////////////////////////
  // Basic types
  ////////////////////////////////////////

  typedef logic [`ID_XLEN-1:0]      word_t;
  typedef logic [`ID_RF_ADDR_W-1:0] rf_addr_t;

  // Major opcodes handled by the decoder
  typedef enum logic [`ID_OPCODE_W-1:0] {
    OPC_LUI    = 7'h37,
    OPC_AUIPC  = 7'h17,
    OPC_JAL    = 7'h6f,
    OPC_JALR   = 7'h67,
    OPC_BRANCH = 7'h63,
    OPC_LOAD   = 7'h03,
    OPC_STORE  = 7'h23,
    OPC_OPIMM  = 7'h13,
    OPC_OP     = 7'h33
  } rv_opcode_e;

  // Arithmetic ops first, branch compares after
  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  ////////////////////////////////////////
  // Mux selects
  ////////////////////////////////////////

  typedef enum logic [1:0] {SEL_REGFILE, SEL_FW_EX, SEL_FW_WB} fw_sel_e;
  typedef enum logic [1:0] {OP_A_NONE, OP_A_REG, OP_A_PC, OP_A_IMM} op_a_sel_e;
  typedef enum logic [1:0] {OP_B_NONE, OP_B_REG, OP_B_IMM} op_b_sel_e;
  typedef enum logic [1:0] {OP_C_NONE, OP_C_REG, OP_C_BCH} op_c_sel_e;
  typedef enum logic [1:0] {IMMB_I, IMMB_S, IMMB_U, IMMB_PCINCR} imm_b_sel_e;
  typedef enum logic [1:0] {BJ_JAL, BJ_JALR, BJ_BCH} bch_jmp_sel_e;

  ////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////

  // Decoder output, consumed inside the stage
  typedef struct packed {
    logic         alu_en;
    logic         alu_bch;
    logic         alu_jmp;
    logic         alu_jmpr;
    alu_op_e      alu_op;
    logic         lsu_en;
    logic         lsu_we;
    logic [1:0]   lsu_size;
    logic         lsu_sext;
    logic         rf_we;
    logic         illegal;
    op_a_sel_e    op_a_sel;
    op_b_sel_e    op_b_sel;
    op_c_sel_e    op_c_sel;
    imm_b_sel_e   imm_b_sel;
    bch_jmp_sel_e bch_jmp_sel;
  } dec_ctrl_t;

  typedef struct packed {
    logic  instr_valid;
    word_t pc;
    word_t instr;
  } if_id_pipe_t;

  // From the bypass logic in the controller
  typedef struct packed {
    fw_sel_e [`ID_NUM_RS-1:0] fw_sel;
    logic                     deassert_we;
  } ctrl_byp_t;

  typedef struct packed {
    logic kill_id;
    logic halt_id;
  } ctrl_fsm_t;

  typedef struct packed {
    logic       instr_valid;
    logic       alu_en;
    logic       alu_bch;
    logic       alu_jmp;
    alu_op_e    alu_op;
    word_t      operand_a;
    word_t      operand_b;
    word_t      operand_c;
    logic       lsu_en;
    logic       lsu_we;
    logic [1:0] lsu_size;
    logic       lsu_sext;
    logic       rf_we;
    rf_addr_t   rf_waddr;
    logic       illegal_insn;
    word_t      pc;
    word_t      instr;
  } id_ex_pipe_t;

endpackage

//--- hw/id_stage/instr_decoder.sv
`timescale 1ns/10ps
`include "id_settings.svh"

module instr_decoder import id_pkg::*; (
  input  word_t                       instr_i,
  input  logic                        deassert_we_i,
  output dec_ctrl_t                   ctrl_o,
  output rf_addr_t [`ID_NUM_RS-1:0]   rf_raddr_o,
  output logic [`ID_NUM_RS-1:0]       rf_re_o,
  output rf_addr_t                    rf_waddr_o
);

  rv_opcode_e  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;

  assign opcode = rv_opcode_e'(instr_i[`ID_OPCODE_W-1:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Register addresses come straight from the fixed field positions
  assign rf_raddr_o[0] = instr_i[`ID_RS1_LSB +: `ID_RF_ADDR_W];
  assign rf_raddr_o[1] = instr_i[`ID_RS2_LSB +: `ID_RF_ADDR_W];
  assign rf_waddr_o    = instr_i[`ID_RD_LSB +: `ID_RF_ADDR_W];

  // Shared funct3 map for OP and OP-IMM, alt picks SUB or SRA
  function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  ////////////////////////////////////////
  // Main decode
  ////////////////////////////////////////

  always_comb begin : decode
    ctrl_o  = '0;
    rf_re_o = '0;
    case (opcode)
      OPC_LUI, OPC_AUIPC: begin
        // LUI adds to a zero operand A, since rs1 is not read
        ctrl_o.alu_en    = 1'b1;
        ctrl_o.rf_we     = 1'b1;
        ctrl_o.op_a_sel  = (opcode == OPC_LUI) ? OP_A_REG : OP_A_PC;
        ctrl_o.op_b_sel  = OP_B_IMM;
        ctrl_o.imm_b_sel = IMMB_U;
      end
      OPC_JAL, OPC_JALR: begin
        // Link value is PC plus 4, computed in the ALU
        ctrl_o.alu_en      = 1'b1;
        ctrl_o.alu_jmp     = 1'b1;
        ctrl_o.alu_jmpr    = (opcode == OPC_JALR);
        ctrl_o.rf_we       = 1'b1;
        ctrl_o.op_a_sel    = OP_A_PC;
        ctrl_o.op_b_sel    = OP_B_IMM;
        ctrl_o.imm_b_sel   = IMMB_PCINCR;
        ctrl_o.bch_jmp_sel = (opcode == OPC_JALR) ? BJ_JALR : BJ_JAL;
        rf_re_o[0]         = (opcode == OPC_JALR);
        ctrl_o.illegal     = (opcode == OPC_JALR) && (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        ctrl_o.alu_en      = 1'b1;
        ctrl_o.alu_bch     = 1'b1;
        ctrl_o.op_a_sel    = OP_A_REG;
        ctrl_o.op_b_sel    = OP_B_REG;
        ctrl_o.op_c_sel    = OP_C_BCH;
        ctrl_o.bch_jmp_sel = BJ_BCH;
        rf_re_o            = 2'b11;
        case (funct3)
          3'b000:  ctrl_o.alu_op = ALU_EQ;
          3'b001:  ctrl_o.alu_op = ALU_NE;
          3'b100:  ctrl_o.alu_op = ALU_LT;
          3'b101:  ctrl_o.alu_op = ALU_GE;
          3'b110:  ctrl_o.alu_op = ALU_LTU;
          3'b111:  ctrl_o.alu_op = ALU_GEU;
          default: ctrl_o.illegal = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        ctrl_o.lsu_en    = 1'b1;
        ctrl_o.rf_we     = 1'b1;
        ctrl_o.lsu_size  = funct3[1:0];
        ctrl_o.lsu_sext  = !funct3[2];
        ctrl_o.op_a_sel  = OP_A_REG;
        ctrl_o.op_b_sel  = OP_B_IMM;
        ctrl_o.imm_b_sel = IMMB_I;
        rf_re_o[0]       = 1'b1;
        // No double word and no unsigned word
        ctrl_o.illegal   = (funct3[1:0] == 2'b11) || (funct3[2] && funct3[1]);
      end
      OPC_STORE: begin
        ctrl_o.lsu_en    = 1'b1;
        ctrl_o.lsu_we    = 1'b1;
        ctrl_o.lsu_size  = funct3[1:0];
        ctrl_o.op_a_sel  = OP_A_REG;
        ctrl_o.op_b_sel  = OP_B_IMM;
        ctrl_o.op_c_sel  = OP_C_REG;
        ctrl_o.imm_b_sel = IMMB_S;
        rf_re_o          = 2'b11;
        ctrl_o.illegal   = funct3[2] || (funct3[1:0] == 2'b11);
      end
      OPC_OPIMM: begin
        ctrl_o.alu_en    = 1'b1;
        ctrl_o.rf_we     = 1'b1;
        ctrl_o.op_a_sel  = OP_A_REG;
        ctrl_o.op_b_sel  = OP_B_IMM;
        ctrl_o.imm_b_sel = IMMB_I;
        ctrl_o.alu_op    = alu_from_funct3(funct3, (funct3 == 3'b101) && instr_i[30]);
        rf_re_o[0]       = 1'b1;
        // Shift amounts only allow the SRAI marker in funct7
        if (funct3 == 3'b001) begin
          ctrl_o.illegal = (funct7 != 7'b0000000);
        end else if (funct3 == 3'b101) begin
          ctrl_o.illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
        end
      end
      OPC_OP: begin
        ctrl_o.alu_en   = 1'b1;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_a_sel = OP_A_REG;
        ctrl_o.op_b_sel = OP_B_REG;
        ctrl_o.alu_op   = alu_from_funct3(funct3, instr_i[30]);
        rf_re_o         = 2'b11;
        ctrl_o.illegal  = !((funct7 == 7'b0000000) ||
                            ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      default: ctrl_o.illegal = 1'b1;
    endcase

    // Illegal encodings must not cause any side effect downstream
    if (ctrl_o.illegal) begin
      ctrl_o.alu_en   = 1'b0;
      ctrl_o.alu_bch  = 1'b0;
      ctrl_o.alu_jmp  = 1'b0;
      ctrl_o.alu_jmpr = 1'b0;
      ctrl_o.lsu_en   = 1'b0;
      ctrl_o.lsu_we   = 1'b0;
      ctrl_o.rf_we    = 1'b0;
      rf_re_o         = '0;
    end
    if (deassert_we_i) begin
      ctrl_o.rf_we = 1'b0;
    end
  end

  // Exactly one of illegal, ALU or LSU per instruction
  always_comb begin : chk_illegal
    assert ($onehot({ctrl_o.illegal, ctrl_o.alu_en, ctrl_o.lsu_en}))
      else $error("decoder unit enables do not match the legality of the instruction");
  end

endmodule

//--- hw/id_stage/operand_fwd_lane.sv
`timescale 1ns/10ps

module operand_fwd_lane import id_pkg::*; (
  input  word_t   rf_rdata_i,
  input  word_t   wdata_ex_i,
  input  word_t   wdata_wb_i,
  input  fw_sel_e fw_sel_i,
  input  logic    re_i,
  output word_t   operand_o
);

  word_t fw_word;

  // Youngest producer is EX, then WB, else the register file
  always_comb begin : fw_mux
    case (fw_sel_i)
      SEL_FW_EX: fw_word = wdata_ex_i;
      SEL_FW_WB: fw_word = wdata_wb_i;
      default:   fw_word = rf_rdata_i;
    endcase
  end

  // Unread port gives zero, LUI relies on this for operand A
  assign operand_o = re_i ? fw_word : '0;

  always_comb begin : chk_fw_sel
    assert ($isunknown(fw_sel_i) || (fw_sel_i inside {SEL_REGFILE, SEL_FW_EX, SEL_FW_WB}))
      else $error("forwarding select out of range");
  end

endmodule

//--- hw/id_stage/operand_select.sv
`timescale 1ns/10ps
`include "id_settings.svh"

module operand_select import id_pkg::*; (
  input  word_t                    instr_i,
  input  word_t                    pc_i,
  input  dec_ctrl_t                ctrl_i,
  input  word_t [`ID_NUM_RS-1:0]   fw_operand_i,
  output word_t                    operand_a_o,
  output word_t                    operand_b_o,
  output word_t                    operand_c_o,
  output word_t                    jmp_target_o
);

  word_t imm_i_type;
  word_t imm_s_type;
  word_t imm_sb_type;
  word_t imm_u_type;
  word_t imm_uj_type;
  word_t imm_z_type;
  word_t imm_opb;
  word_t bch_target;
  word_t jalr_target;

  ////////////////////////////////////////
  // Immediates
  ////////////////////////////////////////

  // Sign extended from bit 31 in every format
  assign imm_i_type  = {{(`ID_XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type  = {{(`ID_XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_sb_type = {{(`ID_XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
                        instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_u_type  = {instr_i[31:12], 12'b0};
  assign imm_uj_type = {{(`ID_XLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12],
                        instr_i[20], instr_i[30:21], 1'b0};
  // rs1 field as an unsigned immediate
  assign imm_z_type  = {{(`ID_XLEN-`ID_RF_ADDR_W){1'b0}},
                        instr_i[`ID_RS1_LSB +: `ID_RF_ADDR_W]};

  ////////////////////////////////////////
  // Targets
  ////////////////////////////////////////

  assign bch_target  = pc_i + imm_sb_type;
  // JALR base comes from the rs1 lane, LSB forced to zero
  assign jalr_target = (fw_operand_i[0] + imm_i_type) & ~word_t'(1);

  always_comb begin : jmp_target_mux
    case (ctrl_i.bch_jmp_sel)
      BJ_JALR: jmp_target_o = jalr_target;
      BJ_BCH:  jmp_target_o = bch_target;
      default: jmp_target_o = pc_i + imm_uj_type;
    endcase
  end

  ////////////////////////////////////////
  // Operand muxes
  ////////////////////////////////////////

  always_comb begin : operand_a_mux
    case (ctrl_i.op_a_sel)
      OP_A_PC:  operand_a_o = pc_i;
      OP_A_IMM: operand_a_o = imm_z_type;
      default:  operand_a_o = fw_operand_i[0];
    endcase
  end

  // Immediate for operand B, PCINCR gives the link offset
  always_comb begin : imm_b_mux
    case (ctrl_i.imm_b_sel)
      IMMB_S:      imm_opb = imm_s_type;
      IMMB_U:      imm_opb = imm_u_type;
      IMMB_PCINCR: imm_opb = word_t'(`ID_PC_INCR);
      default:     imm_opb = imm_i_type;
    endcase
  end

  always_comb begin : operand_b_mux
    case (ctrl_i.op_b_sel)
      OP_B_IMM: operand_b_o = imm_opb;
      default:  operand_b_o = fw_operand_i[1];
    endcase
  end

  // Store data or branch target
  always_comb begin : operand_c_mux
    case (ctrl_i.op_c_sel)
      OP_C_BCH: operand_c_o = bch_target;
      default:  operand_c_o = fw_operand_i[1];
    endcase
  end

endmodule

//--- hw/id_stage/id_ex_pipe_reg.sv
`timescale 1ns/10ps

module id_ex_pipe_reg import id_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  if_id_pipe_t if_id_pipe_i,
  input  ctrl_fsm_t   ctrl_fsm_i,
  input  dec_ctrl_t   ctrl_i,
  input  rf_addr_t    rf_waddr_i,
  input  word_t       operand_a_i,
  input  word_t       operand_b_i,
  input  word_t       operand_c_i,
  input  logic        ex_ready_i,
  output logic        id_ready_o,
  output logic        id_valid_o,
  output id_ex_pipe_t id_ex_pipe_o
);

  ////////////////////////////////////////
  // Stage handshake
  ////////////////////////////////////////

  // Halt blocks both directions, kill drains ID regardless of EX
  assign id_valid_o = if_id_pipe_i.instr_valid && !ctrl_fsm_i.kill_id && !ctrl_fsm_i.halt_id;
  assign id_ready_o = ctrl_fsm_i.kill_id || (ex_ready_i && !ctrl_fsm_i.halt_id);

  ////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin : id_ex_regs
    if (!rst_n) begin
      id_ex_pipe_o <= '0;
    end else if (id_valid_o && ex_ready_i) begin
      id_ex_pipe_o.instr_valid <= 1'b1;

      // Operands only update when the instruction uses them
      if (ctrl_i.op_a_sel != OP_A_NONE) begin
        id_ex_pipe_o.operand_a <= operand_a_i;
      end
      if (ctrl_i.op_b_sel != OP_B_NONE) begin
        id_ex_pipe_o.operand_b <= operand_b_i;
      end
      if (ctrl_i.op_c_sel != OP_C_NONE) begin
        id_ex_pipe_o.operand_c <= operand_c_i;
      end

      id_ex_pipe_o.alu_en <= ctrl_i.alu_en;
      if (ctrl_i.alu_en) begin
        id_ex_pipe_o.alu_bch <= ctrl_i.alu_bch;
        id_ex_pipe_o.alu_jmp <= ctrl_i.alu_jmp;
        id_ex_pipe_o.alu_op  <= ctrl_i.alu_op;
      end

      id_ex_pipe_o.lsu_en <= ctrl_i.lsu_en;
      if (ctrl_i.lsu_en) begin
        id_ex_pipe_o.lsu_we   <= ctrl_i.lsu_we;
        id_ex_pipe_o.lsu_size <= ctrl_i.lsu_size;
        id_ex_pipe_o.lsu_sext <= ctrl_i.lsu_sext;
      end

      id_ex_pipe_o.rf_we <= ctrl_i.rf_we;
      if (ctrl_i.rf_we) begin
        id_ex_pipe_o.rf_waddr <= rf_waddr_i;
      end

      // Kept for exception handling in later stages
      id_ex_pipe_o.illegal_insn <= ctrl_i.illegal;
      id_ex_pipe_o.pc           <= if_id_pipe_i.pc;
      id_ex_pipe_o.instr        <= if_id_pipe_i.instr;
    end else if (ex_ready_i) begin
      // Bubble, payload keeps its old value
      id_ex_pipe_o.instr_valid <= 1'b0;
    end
  end

  // EX back-pressure freezes the whole bundle
  a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    !ex_ready_i |=> $stable(id_ex_pipe_o))
    else $error("ID/EX bundle changed while EX was stalled");

endmodule

//--- hw/id_stage/id_stage.sv
`timescale 1ns/10ps
`include "id_settings.svh"

module id_stage import id_pkg::*; (
  input  logic                         clk,
  input  logic                         rst_n,
  // IF/ID pipeline and controller
  input  if_id_pipe_t                  if_id_pipe_i,
  input  ctrl_byp_t                    ctrl_byp_i,
  input  ctrl_fsm_t                    ctrl_fsm_i,
  // Register file read ports
  output rf_addr_t [`ID_NUM_RS-1:0]    rf_raddr_o,
  output logic [`ID_NUM_RS-1:0]        rf_re_o,
  input  word_t [`ID_NUM_RS-1:0]       rf_rdata_i,
  // Forwarding data
  input  word_t                        rf_wdata_ex_i,
  input  word_t                        rf_wdata_wb_i,
  // Stage handshake
  input  logic                         ex_ready_i,
  output logic                         id_ready_o,
  output logic                         id_valid_o,
  output word_t                        jmp_target_o,
  output id_ex_pipe_t                  id_ex_pipe_o
);

  dec_ctrl_t                 dec_ctrl;
  rf_addr_t                  rf_waddr;
  word_t [`ID_NUM_RS-1:0]    fw_operand;
  word_t                     operand_a;
  word_t                     operand_b;
  word_t                     operand_c;

  instr_decoder decoder_i (
    .instr_i       (if_id_pipe_i.instr),
    .deassert_we_i (ctrl_byp_i.deassert_we),
    .ctrl_o        (dec_ctrl),
    .rf_raddr_o    (rf_raddr_o),
    .rf_re_o       (rf_re_o),
    .rf_waddr_o    (rf_waddr)
  );

  // One forwarding lane per source register
  for (genvar i = 0; i < `ID_NUM_RS; i++) begin : gen_fw_lane
    operand_fwd_lane fw_lane_i (
      .rf_rdata_i (rf_rdata_i[i]),
      .wdata_ex_i (rf_wdata_ex_i),
      .wdata_wb_i (rf_wdata_wb_i),
      .fw_sel_i   (ctrl_byp_i.fw_sel[i]),
      .re_i       (rf_re_o[i]),
      .operand_o  (fw_operand[i])
    );
  end

  operand_select op_sel_i (
    .instr_i      (if_id_pipe_i.instr),
    .pc_i         (if_id_pipe_i.pc),
    .ctrl_i       (dec_ctrl),
    .fw_operand_i (fw_operand),
    .operand_a_o  (operand_a),
    .operand_b_o  (operand_b),
    .operand_c_o  (operand_c),
    .jmp_target_o (jmp_target_o)
  );

  id_ex_pipe_reg pipe_reg_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .if_id_pipe_i (if_id_pipe_i),
    .ctrl_fsm_i   (ctrl_fsm_i),
    .ctrl_i       (dec_ctrl),
    .rf_waddr_i   (rf_waddr),
    .operand_a_i  (operand_a),
    .operand_b_i  (operand_b),
    .operand_c_i  (operand_c),
    .ex_ready_i   (ex_ready_i),
    .id_ready_o   (id_ready_o),
    .id_valid_o   (id_valid_o),
    .id_ex_pipe_o (id_ex_pipe_o)
  );

endmodule

//--- dv/id_stage_tests.svh
////////////////////////////////////////
// Encoders and stimulus helpers
////////////////////////////////////////

// R type, always the OP major opcode
function automatic word_t enc_r(input logic [6:0] funct7, input rf_addr_t rs2,
                                input rf_addr_t rs1, input logic [2:0] funct3,
                                input rf_addr_t rd);
  return {funct7, rs2, rs1, funct3, rd, 7'h33};
endfunction

function automatic word_t enc_i(input logic [11:0] imm, input rf_addr_t rs1,
                                input logic [2:0] funct3, input rf_addr_t rd,
                                input logic [6:0] opcode);
  return {imm, rs1, funct3, rd, opcode};
endfunction

function automatic word_t enc_s(input logic [11:0] imm, input rf_addr_t rs2,
                                input rf_addr_t rs1, input logic [2:0] funct3);
  return {imm[11:5], rs2, rs1, funct3, imm[4:0], 7'h23};
endfunction

// Branch offset is scrambled across the word, bit 0 dropped
function automatic word_t enc_b(input logic [12:0] imm, input rf_addr_t rs2,
                                input rf_addr_t rs1, input logic [2:0] funct3);
  return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], 7'h63};
endfunction

function automatic word_t enc_u(input logic [19:0] imm, input rf_addr_t rd,
                                input logic [6:0] opcode);
  return {imm, rd, opcode};
endfunction

function automatic word_t enc_j(input logic [20:0] imm, input rf_addr_t rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
endfunction

function automatic word_t sign_extend(input word_t value, input int width);
  word_t mask;
  mask = ~word_t'(0) << width;
  return value[width-1] ? (value | mask) : (value & ~mask);
endfunction

function automatic rf_addr_t rand_reg();
  return rf_addr_t'($random(seed));
endfunction

// Word aligned PC
function automatic word_t rand_pc();
  word_t r;
  r = $random(seed);
  return {r[31:2], 2'b00};
endfunction

// Present one valid instruction, returns 2 ns after the edge
task automatic drive_instr(input word_t instr, input word_t pc);
  @(posedge clk);
  #1;
  if_id_pipe.instr_valid = 1'b1;
  if_id_pipe.pc          = pc;
  if_id_pipe.instr       = instr;
  #1;
endtask

// Wait for the valid and ready pair, then drop valid after the edge
task automatic wait_transfer();
  int waited;
  waited = 0;
  while (!(id_valid && ex_ready) && waited < XFER_LIMIT) begin
    @(posedge clk);
    #2;
    waited++;
  end
  if (!(id_valid && ex_ready)) begin
    errors++;
    $display("No transfer from ID to EX within %0d cycles at %0t", XFER_LIMIT, $time);
  end else begin
    @(posedge clk);
    #1;
    if_id_pipe.instr_valid = 1'b0;
    #1;
  end
endtask

////////////////////////////////////////
// Directed tests
////////////////////////////////////////

task automatic test_reset_state();
  check_bit("instr_valid", id_ex_pipe.instr_valid, 1'b0);
  check_bit("alu_en", id_ex_pipe.alu_en, 1'b0);
  check_bit("lsu_en", id_ex_pipe.lsu_en, 1'b0);
  check_bit("rf_we", id_ex_pipe.rf_we, 1'b0);
  check_bit("illegal_insn", id_ex_pipe.illegal_insn, 1'b0);
endtask

task automatic test_op(input logic [6:0] funct7, input logic [2:0] funct3,
                       input alu_op_e exp_op);
  rf_addr_t rd;
  rf_addr_t rs1;
  rf_addr_t rs2;
  rd  = rand_reg();
  rs1 = rand_reg();
  rs2 = rand_reg();
  drive_instr(enc_r(funct7, rs2, rs1, funct3, rd), rand_pc());
  // R type reads both source registers
  check_bit("rf_re_o[0]", rf_re[0], 1'b1);
  check_bit("rf_re_o[1]", rf_re[1], 1'b1);
  wait_transfer();
  check_alu_op("alu_op", id_ex_pipe.alu_op, exp_op);
  check_word("rf_waddr", word_t'(id_ex_pipe.rf_waddr), word_t'(rd));
  check_word("operand_a", id_ex_pipe.operand_a, rf_value(rs1));
  check_word("operand_b", id_ex_pipe.operand_b, rf_value(rs2));
  check_bit("alu_en", id_ex_pipe.alu_en, 1'b1);
  check_bit("rf_we", id_ex_pipe.rf_we, 1'b1);
endtask

task automatic test_opimm();
  rf_addr_t    rd;
  rf_addr_t    rs1;
  logic [11:0] imm;
  rd  = rand_reg();
  rs1 = rand_reg();
  imm = 12'($random(seed));
  // ADDI
  drive_instr(enc_i(imm, rs1, 3'b000, rd, 7'h13), rand_pc());
  check_bit("rf_re_o[0]", rf_re[0], 1'b1);
  check_bit("rf_re_o[1]", rf_re[1], 1'b0);
  wait_transfer();
  check_alu_op("alu_op", id_ex_pipe.alu_op, ALU_ADD);
  check_word("operand_a", id_ex_pipe.operand_a, rf_value(rs1));
  check_word("operand_b", id_ex_pipe.operand_b, sign_extend(word_t'(imm), 12));
  check_word("rf_waddr", word_t'(id_ex_pipe.rf_waddr), word_t'(rd));
endtask

task automatic test_load_store();
  rf_addr_t    rd;
  rf_addr_t    rs1;
  rf_addr_t    rs2;
  logic [11:0] imm;
  rd  = rand_reg();
  rs1 = rand_reg();
  rs2 = rand_reg();
  imm = 12'($random(seed));
  // LW, signed word
  drive_instr(enc_i(imm, rs1, 3'b010, rd, 7'h03), rand_pc());
  wait_transfer();
  check_bit("lsu_en", id_ex_pipe.lsu_en, 1'b1);
  check_bit("lsu_we", id_ex_pipe.lsu_we, 1'b0);
  check_bit("lsu_sext", id_ex_pipe.lsu_sext, 1'b1);
  check_word("lsu_size", word_t'(id_ex_pipe.lsu_size), 32'd2);
  check_word("operand_a", id_ex_pipe.operand_a, rf_value(rs1));
  check_word("operand_b", id_ex_pipe.operand_b, sign_extend(word_t'(imm), 12));
  // SW, data comes from rs2
  drive_instr(enc_s(imm, rs2, rs1, 3'b010), rand_pc());
  wait_transfer();
  check_bit("lsu_en", id_ex_pipe.lsu_en, 1'b1);
  check_bit("lsu_we", id_ex_pipe.lsu_we, 1'b1);
  check_word("lsu_size", word_t'(id_ex_pipe.lsu_size), 32'd2);
  check_word("operand_b", id_ex_pipe.operand_b, sign_extend(word_t'(imm), 12));
  check_word("operand_c", id_ex_pipe.operand_c, rf_value(rs2));
endtask

task automatic test_lui();
  rf_addr_t    rd;
  logic [19:0] imm;
  rd  = rand_reg();
  imm = 20'($random(seed));
  drive_instr(enc_u(imm, rd, 7'h37), rand_pc());
  // U type reads no source register
  check_bit("rf_re_o[0]", rf_re[0], 1'b0);
  check_bit("rf_re_o[1]", rf_re[1], 1'b0);
  wait_transfer();
  // rs1 is not read, so operand A is zero
  check_word("operand_a", id_ex_pipe.operand_a, 32'h0);
  check_word("operand_b", id_ex_pipe.operand_b, {imm, 12'h000});
  check_word("rf_waddr", word_t'(id_ex_pipe.rf_waddr), word_t'(rd));
endtask

task automatic test_forwarding(input fw_sel_e sel_a, input fw_sel_e sel_b);
  rf_addr_t rs1;
  rf_addr_t rs2;
  rs1                = rand_reg();
  rs2                = rand_reg();
  rf_wdata_ex        = $random(seed);
  rf_wdata_wb        = $random(seed);
  ctrl_byp.fw_sel[0] = sel_a;
  ctrl_byp.fw_sel[1] = sel_b;
  drive_instr(enc_r(7'h00, rs2, rs1, 3'b000, rand_reg()), rand_pc());
  wait_transfer();
  check_word("operand_a", id_ex_pipe.operand_a, (sel_a == SEL_FW_EX) ? rf_wdata_ex : rf_wdata_wb);
  check_word("operand_b", id_ex_pipe.operand_b, (sel_b == SEL_FW_EX) ? rf_wdata_ex : rf_wdata_wb);
  ctrl_byp.fw_sel[0] = SEL_REGFILE;
  ctrl_byp.fw_sel[1] = SEL_REGFILE;
endtask

task automatic test_branch();
  rf_addr_t    rs1;
  rf_addr_t    rs2;
  logic [12:0] imm;
  word_t       pc;
  word_t       target;
  rs1    = rand_reg();
  rs2    = rand_reg();
  imm    = {12'($random(seed)), 1'b0};
  pc     = rand_pc();
  target = pc + sign_extend(word_t'(imm), 13);
  // BEQ
  drive_instr(enc_b(imm, rs2, rs1, 3'b000), pc);
  check_word("jmp_target_o", jmp_target, target);
  wait_transfer();
  check_bit("alu_bch", id_ex_pipe.alu_bch, 1'b1);
  check_alu_op("alu_op", id_ex_pipe.alu_op, ALU_EQ);
  check_word("operand_a", id_ex_pipe.operand_a, rf_value(rs1));
  check_word("operand_b", id_ex_pipe.operand_b, rf_value(rs2));
  check_word("operand_c", id_ex_pipe.operand_c, target);
endtask

task automatic test_jumps();
  rf_addr_t    rs1;
  logic [20:0] imm_j;
  logic [11:0] imm_i;
  word_t       pc;
  rs1   = rand_reg();
  imm_j = {20'($random(seed)), 1'b0};
  imm_i = 12'($random(seed));
  pc    = rand_pc();
  drive_instr(enc_j(imm_j, rand_reg()), pc);
  check_word("jmp_target_o", jmp_target, pc + sign_extend(word_t'(imm_j), 21));
  wait_transfer();
  check_bit("alu_jmp", id_ex_pipe.alu_jmp, 1'b1);
  check_word("operand_a", id_ex_pipe.operand_a, pc);
  check_word("operand_b", id_ex_pipe.operand_b, 32'd4);
  pc = rand_pc();
  // JALR target has bit 0 cleared
  drive_instr(enc_i(imm_i, rs1, 3'b000, rand_reg(), 7'h67), pc);
  check_word("jmp_target_o", jmp_target,
             (rf_value(rs1) + sign_extend(word_t'(imm_i), 12)) & ~32'h1);
  wait_transfer();
  check_word("operand_a", id_ex_pipe.operand_a, pc);
  check_word("operand_b", id_ex_pipe.operand_b, 32'd4);
endtask

task automatic test_illegal();
  word_t r;
  r = $random(seed);
  // SYSTEM major opcode is outside the decoded set
  drive_instr({r[31:7], 7'h73}, rand_pc());
  wait_transfer();
  check_bit("illegal_insn", id_ex_pipe.illegal_insn, 1'b1);
  check_bit("alu_en", id_ex_pipe.alu_en, 1'b0);
  check_bit("lsu_en", id_ex_pipe.lsu_en, 1'b0);
  check_bit("rf_we", id_ex_pipe.rf_we, 1'b0);
endtask

task automatic test_backpressure();
  id_ex_pipe_t held;
  word_t       pc;
  pc = rand_pc();
  @(posedge clk);
  #1;
  ex_ready   = 1'b0;
  if_id_pipe = {1'b1, pc, enc_r(7'h00, rand_reg(), rand_reg(), 3'b000, rand_reg())};
  #1;
  held = id_ex_pipe;
  repeat (3) begin
    check_bit("id_ready_o", id_ready, 1'b0);
    check_bit("instr_valid", id_ex_pipe.instr_valid, held.instr_valid);
    check_word("pc", id_ex_pipe.pc, held.pc);
    check_word("instr", id_ex_pipe.instr, held.instr);
    check_word("operand_a", id_ex_pipe.operand_a, held.operand_a);
    check_word("operand_b", id_ex_pipe.operand_b, held.operand_b);
    @(posedge clk);
    #2;
  end
  @(posedge clk);
  #1;
  ex_ready = 1'b1;
  #1;
  wait_transfer();
  check_word("pc", id_ex_pipe.pc, pc);
endtask

task automatic test_halt();
  word_t pc;
  pc = rand_pc();
  @(posedge clk);
  #1;
  ctrl_fsm.halt_id = 1'b1;
  if_id_pipe       = {1'b1, pc, enc_u(20'h12345, rand_reg(), 7'h17)};
  #1;
  check_bit("id_valid_o", id_valid, 1'b0);
  check_bit("id_ready_o", id_ready, 1'b0);
  @(posedge clk);
  #2;
  check_bit("instr_valid", id_ex_pipe.instr_valid, 1'b0);
  @(posedge clk);
  #1;
  ctrl_fsm.halt_id = 1'b0;
  #1;
  wait_transfer();
  check_word("pc", id_ex_pipe.pc, pc);
endtask

task automatic test_kill();
  word_t old_pc;
  @(posedge clk);
  #1;
  ctrl_fsm.kill_id = 1'b1;
  if_id_pipe       = {1'b1, rand_pc(), enc_r(7'h00, rand_reg(), rand_reg(), 3'b100, 5'd3)};
  #1;
  old_pc = id_ex_pipe.pc;
  check_bit("id_ready_o", id_ready, 1'b1);
  check_bit("id_valid_o", id_valid, 1'b0);
  @(posedge clk);
  #1;
  ctrl_fsm.kill_id       = 1'b0;
  if_id_pipe.instr_valid = 1'b0;
  #1;
  // Bubble, payload keeps the last transferred instruction
  check_bit("instr_valid", id_ex_pipe.instr_valid, 1'b0);
  check_word("pc", id_ex_pipe.pc, old_pc);
endtask

task automatic run_all_tests();
  test_reset_state();
  test_op(7'h00, 3'b000, ALU_ADD);
  test_op(7'h20, 3'b000, ALU_SUB);
  test_op(7'h00, 3'b100, ALU_XOR);
  test_opimm();
  test_load_store();
  test_lui();
  test_forwarding(SEL_FW_EX, SEL_FW_WB);
  test_forwarding(SEL_FW_WB, SEL_FW_EX);
  test_branch();
  test_jumps();
  test_illegal();
  test_backpressure();
  test_halt();
  test_kill();
endtask

//--- dv/tb_id_stage.sv
`timescale 1ns/10ps
`include "id_settings.svh"

module tb_id_stage import id_pkg::*; ();

  // About 20 directed cases of up to 8 cycles each, plus reset and margin
  localparam int MAX_CYCLES = 400;
  // Longest wait for one ID to EX transfer
  localparam int XFER_LIMIT = 10;

  logic                      clk;
  logic                      rst_n;
  if_id_pipe_t               if_id_pipe;
  ctrl_byp_t                 ctrl_byp;
  ctrl_fsm_t                 ctrl_fsm;
  rf_addr_t [`ID_NUM_RS-1:0] rf_raddr;
  logic [`ID_NUM_RS-1:0]     rf_re;
  word_t [`ID_NUM_RS-1:0]    rf_rdata;
  word_t                     rf_wdata_ex;
  word_t                     rf_wdata_wb;
  logic                      ex_ready;
  logic                      id_ready;
  logic                      id_valid;
  word_t                     jmp_target;
  id_ex_pipe_t               id_ex_pipe;

  integer seed   = 39;
  int     errors = 0;
  int     checks = 0;
  int     cycles = 0;

  id_stage dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .if_id_pipe_i  (if_id_pipe),
    .ctrl_byp_i    (ctrl_byp),
    .ctrl_fsm_i    (ctrl_fsm),
    .rf_raddr_o    (rf_raddr),
    .rf_re_o       (rf_re),
    .rf_rdata_i    (rf_rdata),
    .rf_wdata_ex_i (rf_wdata_ex),
    .rf_wdata_wb_i (rf_wdata_wb),
    .ex_ready_i    (ex_ready),
    .id_ready_o    (id_ready),
    .id_valid_o    (id_valid),
    .jmp_target_o  (jmp_target),
    .id_ex_pipe_o  (id_ex_pipe)
  );

  // 8 ns clock
  initial begin : clk_gen
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////
  // Register file model
  ////////////////////////////////////////

  // Every address bit shows up twice in the read word
  function automatic word_t rf_value(input rf_addr_t addr);
    return {3'b101, addr, 8'h5a, 3'b011, addr, 8'hc3};
  endfunction

  always_comb begin : rf_model
    for (int i = 0; i < `ID_NUM_RS; i++) begin
      rf_rdata[i] = rf_value(rf_raddr[i]);
    end
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_alu_op(input string name, input alu_op_e got, input alu_op_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // Hard stop in case a test never returns
  always @(posedge clk) begin : watchdog
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Run stopped at the %0d cycle limit before the tests finished", MAX_CYCLES);
      $display("sim failed");
      $finish;
    end
  end

  initial begin : main
    rst_n       = 1'b0;
    if_id_pipe  = '0;
    ctrl_byp    = '0;
    ctrl_fsm    = '0;
    rf_wdata_ex = '0;
    rf_wdata_wb = '0;
    ex_ready    = 1'b1;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    #1;
    run_all_tests();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  `include "id_stage_tests.svh"

endmodule

//--- filelist.f
+incdir+common
+incdir+dv
common/id_pkg.sv
hw/id_stage/instr_decoder.sv
hw/id_stage/operand_fwd_lane.sv
hw/id_stage/operand_select.sv
hw/id_stage/id_ex_pipe_reg.sv
hw/id_stage/id_stage.sv
dv/tb_id_stage.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= sim passed

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh dv/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then echo "Result: PASS"; \
	else echo "Result: FAIL"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
